/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int OPC_W  = 7;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // field positions inside a 32-bit instruction
  localparam int OPC_LSB    = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  typedef enum logic [OPC_W-1:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JUMP,     // jal
    BR_JUMP_REG  // jalr
  } br_op_e;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n_i,

  input  logic  redirect_valid_i,
  input  word_t redirect_pc_i,

  output word_t imem_addr_o,
  input  word_t imem_data_i,

  output logic  if_valid_o,
  output word_t if_pc_o,
  output word_t if_inst_o
);

  word_t pc_q;
  word_t pc_next;

  // a redirect from execute overrides sequential fetch
  assign pc_next     = redirect_valid_i ? redirect_pc_i : pc_q + 32'd4;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // fetch/decode register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_valid_o <= 1'b0;
    end else begin
      if_valid_o <= !redirect_valid_i;  // word fetched this cycle is wrong path
    end
  end

  always_ff @(posedge clk) begin
    if_pc_o   <= pc_q;
    if_inst_o <= imem_data_i;
  end

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,

  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  output word_t    rs1_rdata_o,
  output word_t    rs2_rdata_o,

  input  logic     wb_we_i,
  input  reg_idx_t wb_rd_i,
  input  word_t    wb_data_i
);

  // x1..x31 only, x0 has no storage
  word_t regs_q [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_we_i && wb_rd_i != '0) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  assign rs1_rdata_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_rdata_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,

  input  logic     if_valid_i,
  input  word_t    if_pc_i,
  input  word_t    if_inst_i,

  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  input  word_t    rs1_rdata_i,
  input  word_t    rs2_rdata_i,

  input  logic     ex_fwd_we_i,
  input  reg_idx_t ex_fwd_rd_i,
  input  word_t    ex_fwd_data_i,

  input  logic     wb_we_i,
  input  reg_idx_t wb_rd_i,
  input  word_t    wb_data_i,

  input  logic     redirect_valid_i,

  output logic     id_valid_o,
  output word_t    id_pc_o,
  output word_t    id_inst_o,
  output alu_op_e  id_alu_op_o,
  output br_op_e   id_br_op_o,
  output word_t    id_rs1_val_o,
  output word_t    id_rs2_val_o,
  output word_t    id_imm_o,
  output logic     id_use_imm_o,
  output logic     id_use_pc_o,
  output reg_idx_t id_rd_o,
  output logic     id_we_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  reg_idx_t   rd;
  word_t      imm_i, imm_u, imm_b, imm_j;
  alu_op_e    alu_op_arith;
  alu_op_e    alu_op;
  br_op_e     br_op;
  word_t      imm;
  logic       use_imm;
  logic       use_pc;
  logic       writes_rd;
  word_t      rs1_val, rs2_val;

  assign opcode    = opcode_e'(if_inst_i[OPC_LSB +: OPC_W]);
  assign funct3    = if_inst_i[FUNCT3_LSB +: 3];
  assign funct7_b5 = if_inst_i[FUNCT7_LSB + 5];  // sub / sra select
  assign rd        = if_inst_i[RD_LSB +: REG_AW];
  assign rs1_idx_o = if_inst_i[RS1_LSB +: REG_AW];
  assign rs2_idx_o = if_inst_i[RS2_LSB +: REG_AW];

  assign imm_i = {{20{if_inst_i[31]}}, if_inst_i[31:20]};
  assign imm_u = {if_inst_i[31:12], 12'b0};
  assign imm_b = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                  if_inst_i[30:25], if_inst_i[11:8], 1'b0};
  assign imm_j = {{11{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                  if_inst_i[20], if_inst_i[30:21], 1'b0};

  // shared by OP and OP_IMM, addi never becomes sub
  always_comb begin
    case (funct3)
      3'b000:  alu_op_arith = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_arith = ALU_SLL;
      3'b010:  alu_op_arith = ALU_SLT;
      3'b011:  alu_op_arith = ALU_SLTU;
      3'b100:  alu_op_arith = ALU_XOR;
      3'b101:  alu_op_arith = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_arith = ALU_OR;
      default: alu_op_arith = ALU_AND;
    endcase
  end

  always_comb begin
    alu_op    = ALU_ADD;
    br_op     = BR_NONE;
    imm       = '0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op    = alu_op_arith;
        writes_rd = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op    = alu_op_arith;
        imm       = imm_i;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = imm_u;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        case (funct3)
          3'b000:  br_op = BR_EQ;
          3'b001:  br_op = BR_NE;
          3'b100:  br_op = BR_LT;
          3'b101:  br_op = BR_GE;
          default: br_op = BR_NONE;  // bltu/bgeu not supported
        endcase
      end
      OPC_JAL: begin
        br_op     = BR_JUMP;
        imm       = imm_j;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        br_op     = BR_JUMP_REG;
        imm       = imm_i;
        writes_rd = 1'b1;
      end
      default: ;  // anything else retires as a nop
    endcase
  end

  // execute result is youngest, then writeback, then the register file
  always_comb begin
    if (ex_fwd_we_i && ex_fwd_rd_i == rs1_idx_o) begin
      rs1_val = ex_fwd_data_i;
    end else if (wb_we_i && wb_rd_i == rs1_idx_o) begin
      rs1_val = wb_data_i;
    end else begin
      rs1_val = rs1_rdata_i;
    end
    if (ex_fwd_we_i && ex_fwd_rd_i == rs2_idx_o) begin
      rs2_val = ex_fwd_data_i;
    end else if (wb_we_i && wb_rd_i == rs2_idx_o) begin
      rs2_val = wb_data_i;
    end else begin
      rs2_val = rs2_rdata_i;
    end
  end

  // decode/execute register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
    end else begin
      id_valid_o <= if_valid_i && !redirect_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    id_pc_o      <= if_pc_i;
    id_inst_o    <= if_inst_i;
    id_alu_op_o  <= alu_op;
    id_br_op_o   <= br_op;
    id_rs1_val_o <= rs1_val;
    id_rs2_val_o <= rs2_val;
    id_imm_o     <= imm;
    id_use_imm_o <= use_imm;
    id_use_pc_o  <= use_pc;
    id_rd_o      <= rd;
    id_we_o      <= writes_rd && (rd != '0);  // x0 writes are dropped here
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,

  input  logic     id_valid_i,
  input  word_t    id_pc_i,
  input  word_t    id_inst_i,
  input  alu_op_e  id_alu_op_i,
  input  br_op_e   id_br_op_i,
  input  word_t    id_rs1_val_i,
  input  word_t    id_rs2_val_i,
  input  word_t    id_imm_i,
  input  logic     id_use_imm_i,
  input  logic     id_use_pc_i,
  input  reg_idx_t id_rd_i,
  input  logic     id_we_i,

  output logic     ex_fwd_we_o,
  output reg_idx_t ex_fwd_rd_o,
  output word_t    ex_fwd_data_o,

  output logic     redirect_valid_o,
  output word_t    redirect_pc_o,

  output logic     wb_valid_o,
  output word_t    wb_pc_o,
  output word_t    wb_inst_o,
  output logic     wb_we_o,
  output reg_idx_t wb_rd_o,
  output word_t    wb_data_o
);

  word_t      op_a, op_b;
  logic [4:0] shamt;
  logic       eq, lt_s, lt_u;
  word_t      alu_res;
  logic       is_jump;
  logic       taken;
  word_t      target_base, target_sum;
  word_t      result;

  assign op_a  = id_use_pc_i ? id_pc_i : id_rs1_val_i;
  assign op_b  = id_use_imm_i ? id_imm_i : id_rs2_val_i;
  assign shamt = op_b[4:0];

  // branches use rs1/rs2 directly, so the compare is shared with slt
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  always_comb begin
    case (id_alu_op_i)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, lt_u};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  assign is_jump = (id_br_op_i == BR_JUMP) || (id_br_op_i == BR_JUMP_REG);

  always_comb begin
    case (id_br_op_i)
      BR_EQ:       taken = eq;
      BR_NE:       taken = !eq;
      BR_LT:       taken = lt_s;
      BR_GE:       taken = !lt_s;
      BR_JUMP,
      BR_JUMP_REG: taken = 1'b1;
      default:     taken = 1'b0;
    endcase
  end

  // jalr is rs1 relative with bit 0 cleared, everything else pc relative
  assign target_base = (id_br_op_i == BR_JUMP_REG) ? id_rs1_val_i : id_pc_i;
  assign target_sum  = target_base + id_imm_i;

  assign redirect_valid_o = id_valid_i && taken;
  assign redirect_pc_o    = (id_br_op_i == BR_JUMP_REG) ? {target_sum[XLEN-1:1], 1'b0}
                                                        : target_sum;

  assign result = is_jump ? id_pc_i + 32'd4 : alu_res;  // link address

  assign ex_fwd_we_o   = id_valid_i && id_we_i;
  assign ex_fwd_rd_o   = id_rd_i;
  assign ex_fwd_data_o = result;

  // writeback register, also the commit port
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else begin
      wb_valid_o <= id_valid_i;
      wb_we_o    <= ex_fwd_we_o;
      wb_rd_o    <= ex_fwd_we_o ? id_rd_i : '0;  // zero when nothing is written
      wb_data_o  <= ex_fwd_we_o ? result : '0;
    end
  end

  always_ff @(posedge clk) begin
    wb_pc_o   <= id_pc_i;
    wb_inst_o <= id_inst_i;
  end

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic     clk,
  input  logic     rst_n_i,

  output word_t    imem_addr_o,
  input  word_t    imem_data_i,

  output logic     commit_valid_o,
  output word_t    commit_pc_o,
  output word_t    commit_inst_o,
  output logic     commit_we_o,
  output reg_idx_t commit_rd_o,
  output word_t    commit_data_o
);

  logic     if_valid;
  word_t    if_pc, if_inst;

  reg_idx_t rs1_idx, rs2_idx;
  word_t    rs1_rdata, rs2_rdata;

  logic     id_valid;
  word_t    id_pc, id_inst;
  alu_op_e  id_alu_op;
  br_op_e   id_br_op;
  word_t    id_rs1_val, id_rs2_val, id_imm;
  logic     id_use_imm, id_use_pc;
  reg_idx_t id_rd;
  logic     id_we;

  logic     ex_fwd_we;
  reg_idx_t ex_fwd_rd;
  word_t    ex_fwd_data;

  logic     redirect_valid;
  word_t    redirect_pc;

  logic     wb_valid;
  word_t    wb_pc, wb_inst;
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .imem_addr_o      (imem_addr_o),
    .imem_data_i      (imem_data_i),
    .if_valid_o       (if_valid),
    .if_pc_o          (if_pc),
    .if_inst_o        (if_inst)
  );

  gpr_file u_gpr (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rs1_idx_i   (rs1_idx),
    .rs2_idx_i   (rs2_idx),
    .rs1_rdata_o (rs1_rdata),
    .rs2_rdata_o (rs2_rdata),
    .wb_we_i     (wb_we),
    .wb_rd_i     (wb_rd),
    .wb_data_i   (wb_data)
  );

  decode_stage u_decode (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .if_valid_i       (if_valid),
    .if_pc_i          (if_pc),
    .if_inst_i        (if_inst),
    .rs1_idx_o        (rs1_idx),
    .rs2_idx_o        (rs2_idx),
    .rs1_rdata_i      (rs1_rdata),
    .rs2_rdata_i      (rs2_rdata),
    .ex_fwd_we_i      (ex_fwd_we),
    .ex_fwd_rd_i      (ex_fwd_rd),
    .ex_fwd_data_i    (ex_fwd_data),
    .wb_we_i          (wb_we),
    .wb_rd_i          (wb_rd),
    .wb_data_i        (wb_data),
    .redirect_valid_i (redirect_valid),
    .id_valid_o       (id_valid),
    .id_pc_o          (id_pc),
    .id_inst_o        (id_inst),
    .id_alu_op_o      (id_alu_op),
    .id_br_op_o       (id_br_op),
    .id_rs1_val_o     (id_rs1_val),
    .id_rs2_val_o     (id_rs2_val),
    .id_imm_o         (id_imm),
    .id_use_imm_o     (id_use_imm),
    .id_use_pc_o      (id_use_pc),
    .id_rd_o          (id_rd),
    .id_we_o          (id_we)
  );

  execute_stage u_execute (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .id_valid_i       (id_valid),
    .id_pc_i          (id_pc),
    .id_inst_i        (id_inst),
    .id_alu_op_i      (id_alu_op),
    .id_br_op_i       (id_br_op),
    .id_rs1_val_i     (id_rs1_val),
    .id_rs2_val_i     (id_rs2_val),
    .id_imm_i         (id_imm),
    .id_use_imm_i     (id_use_imm),
    .id_use_pc_i      (id_use_pc),
    .id_rd_i          (id_rd),
    .id_we_i          (id_we),
    .ex_fwd_we_o      (ex_fwd_we),
    .ex_fwd_rd_o      (ex_fwd_rd),
    .ex_fwd_data_o    (ex_fwd_data),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .wb_valid_o       (wb_valid),
    .wb_pc_o          (wb_pc),
    .wb_inst_o        (wb_inst),
    .wb_we_o          (wb_we),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data)
  );

  // retiring instruction straight from the writeback register
  assign commit_valid_o = wb_valid;
  assign commit_pc_o    = wb_pc;
  assign commit_inst_o  = wb_inst;
  assign commit_we_o    = wb_we;
  assign commit_rd_o    = wb_rd;
  assign commit_data_o  = wb_data;

endmodule

`default_nettype wire

/* tb/cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb import rv_pkg::*; ();

  localparam word_t RESET_PC     = 32'h0000_0000;
  localparam int    RESET_CYCLES = 10;
  localparam int    MEM_WORDS    = 512;
  localparam int    ROM_WORDS    = 256;  // program area at the start of the data file
  localparam int    REC_BASE     = 256;  // commit count, then the records
  localparam int    REC_WORDS    = 5;    // pc, inst, we, rd, data
  localparam word_t NOP          = 32'h0000_0013;  // addi x0, x0, 0

  logic     clk = 1'b0;
  logic     rst_n_i;
  word_t    imem_addr;
  word_t    imem_data;
  logic     commit_valid;
  word_t    commit_pc;
  word_t    commit_inst;
  logic     commit_we;
  reg_idx_t commit_rd;
  word_t    commit_data;

  word_t    data_mem [0:MEM_WORDS-1];
  word_t    rom_word;
  logic     rom_hit;
  int       exp_count;
  int       rec_idx;
  int       cycle_cnt;
  int       cycle_limit;
  logic     reset_checked;

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) cpu_core_inst (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .commit_valid_o (commit_valid),
    .commit_pc_o    (commit_pc),
    .commit_inst_o  (commit_inst),
    .commit_we_o    (commit_we),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  always #5 clk = ~clk;

  // instruction rom where words missing from the file read as nop
  assign rom_hit   = (imem_addr < ROM_WORDS * 4);
  assign rom_word  = data_mem[imem_addr[9:2]];
  assign imem_data = (rom_hit && !$isunknown(rom_word)) ? rom_word : NOP;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_value(input string name, input word_t got, input word_t exp);
    stop_with_error($sformatf("FAIL time=%0t %s: got %h, expected %h",
                              $time, name, got, exp));
  endtask

  task automatic finish_run();
    $display("Done: no errors");
    $finish;
  endtask

  // compare one retiring instruction with the next expected record
  task automatic check_commit();
    int       base;
    word_t    exp_pc;
    word_t    exp_inst;
    logic     exp_we;
    reg_idx_t exp_rd;
    word_t    exp_data;
    base     = REC_BASE + 1 + REC_WORDS * rec_idx;
    exp_pc   = data_mem[base];
    exp_inst = data_mem[base + 1];
    exp_we   = data_mem[base + 2][0];
    exp_rd   = data_mem[base + 3][4:0];
    exp_data = data_mem[base + 4];
    assert (commit_pc === exp_pc)
      else report_value("commit_pc_o", commit_pc, exp_pc);
    assert (commit_inst === exp_inst)
      else report_value("commit_inst_o", commit_inst, exp_inst);
    assert (commit_we === exp_we)
      else report_value("commit_we_o", {31'b0, commit_we}, {31'b0, exp_we});
    assert (commit_rd === exp_rd)
      else report_value("commit_rd_o", {27'b0, commit_rd}, {27'b0, exp_rd});
    assert (commit_data === exp_data)
      else report_value("commit_data_o", commit_data, exp_data);
  endtask

  initial begin
    rst_n_i       = 1'b0;
    rec_idx       = 0;
    cycle_cnt     = 0;
    reset_checked = 1'b0;
    $readmemh("tb/program_input.txt", data_mem);
    exp_count   = $isunknown(data_mem[REC_BASE]) ? 0 : int'(data_mem[REC_BASE]);
    cycle_limit = 50 + 8 * exp_count;  // covers squash bubbles with margin
    if (exp_count == 0 || REC_BASE + 1 + REC_WORDS * exp_count > MEM_WORDS) begin
      stop_with_error("the data file holds no usable count of commit records");
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n_i = 1'b1;
    end
  end

  // reset state sampled mid-cycle while reset is held and one cycle after
  always @(negedge clk) begin
    if (!reset_checked) begin
      assert (commit_valid === 1'b0)
        else report_value("commit_valid_o", {31'b0, commit_valid}, 32'd0);
      assert (imem_addr === RESET_PC)
        else report_value("imem_addr_o", imem_addr, RESET_PC);
      if (rst_n_i === 1'b1) begin
        reset_checked = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n_i === 1'b1 && commit_valid !== 1'b0) begin
      assert (commit_valid === 1'b1)
        else stop_with_error("commit_valid_o went unknown after reset");
      check_commit();
      rec_idx++;
      if (rec_idx == exp_count) begin
        finish_run();
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      stop_with_error($sformatf("timeout after %0d cycles with %0d of %0d commits seen",
                                cycle_cnt, rec_idx, exp_count));
    end
  end

endmodule

`default_nettype wire

/* cpu_core.f */
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/gpr_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/cpu_core.sv
tb/cpu_core_tb.sv

/* tb/program_input.txt */
// words 0x000..0x0ff: program image, one instruction word per address
// word 0x100: commit count, then records of pc, inst, we, rd, data
@000
123450B7  // 00 lui   x1, 0x12345
67808093  // 04 addi  x1, x1, 0x678
FFB00113  // 08 addi  x2, x0, -5
002081B3  // 0c add   x3, x1, x2
40208233  // 10 sub   x4, x1, x2
002272B3  // 14 and   x5, x4, x2
0030E333  // 18 or    x6, x1, x3
0020C3B3  // 1c xor   x7, x1, x2
00400413  // 20 addi  x8, x0, 4
008094B3  // 24 sll   x9, x1, x8
00815533  // 28 srl   x10, x2, x8
408155B3  // 2c sra   x11, x2, x8
00112633  // 30 slt   x12, x2, x1
001136B3  // 34 sltu  x13, x2, x1
FFC12713  // 38 slti  x14, x2, -4
FFF0B793  // 3c sltiu x15, x1, -1
FFF0C813  // 40 xori  x16, x1, -1
0F00E893  // 44 ori   x17, x1, 0x0f0
0FF0F913  // 48 andi  x18, x1, 0x0ff
00809993  // 4c slli  x19, x1, 8
01C15A13  // 50 srli  x20, x2, 28
40115A93  // 54 srai  x21, x2, 1
00001B17  // 58 auipc x22, 0x1
00700013  // 5c addi  x0, x0, 7
00100BB3  // 60 add   x23, x0, x1
01708663  // 64 beq   x1, x23, +12 taken
00100C13  // 68 addi  x24, x0, 1 wrong path
00200C13  // 6c addi  x24, x0, 2 wrong path
01709463  // 70 bne   x1, x23, +8 not taken
00114663  // 74 blt   x2, x1, +12 taken
00300C13  // 78 addi  x24, x0, 3 wrong path
00400C13  // 7c addi  x24, x0, 4 wrong path
0020D463  // 80 bge   x1, x2, +8 taken
00500C13  // 84 addi  x24, x0, 5 wrong path
00600C13  // 88 addi  x24, x0, 6
00C00CEF  // 8c jal   x25, +12
00100D13  // 90 addi  x26, x0, 1 wrong path
00200D13  // 94 addi  x26, x0, 2 wrong path
015C8D93  // 98 addi  x27, x25, 0x15
008D8E67  // 9c jalr  x28, 8(x27) target 0xad, bit 0 cleared
00300D13  // a0 addi  x26, x0, 3 wrong path
00400D13  // a4 addi  x26, x0, 4 wrong path
00500D13  // a8 addi  x26, x0, 5 skipped
000E0EB3  // ac add   x29, x28, x0
0000006F  // b0 jal   x0, 0 self loop
@100
00000023  // 35 commits
00000000 123450B7 1 01 12345000
00000004 67808093 1 01 12345678
00000008 FFB00113 1 02 FFFFFFFB
0000000C 002081B3 1 03 12345673
00000010 40208233 1 04 1234567D
00000014 002272B3 1 05 12345679
00000018 0030E333 1 06 1234567B
0000001C 0020C3B3 1 07 EDCBA983
00000020 00400413 1 08 00000004
00000024 008094B3 1 09 23456780
00000028 00815533 1 0A 0FFFFFFF
0000002C 408155B3 1 0B FFFFFFFF
00000030 00112633 1 0C 00000001
00000034 001136B3 1 0D 00000000
00000038 FFC12713 1 0E 00000001
0000003C FFF0B793 1 0F 00000001
00000040 FFF0C813 1 10 EDCBA987
00000044 0F00E893 1 11 123456F8
00000048 0FF0F913 1 12 00000078
0000004C 00809993 1 13 34567800
00000050 01C15A13 1 14 0000000F
00000054 40115A93 1 15 FFFFFFFD
00000058 00001B17 1 16 00001058
0000005C 00700013 0 00 00000000
00000060 00100BB3 1 17 12345678
00000064 01708663 0 00 00000000
00000070 01709463 0 00 00000000
00000074 00114663 0 00 00000000
00000080 0020D463 0 00 00000000
00000088 00600C13 1 18 00000006
0000008C 00C00CEF 1 19 00000090
00000098 015C8D93 1 1B 000000A5
0000009C 008D8E67 1 1C 000000A0
000000AC 000E0EB3 1 1D 000000A0
000000B0 0000006F 0 00 00000000
